//--- Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_fpga_core
RTL_TOP    = fpga_core
FILELIST   = all.f
LOG        = sim.log
FAIL_MSG   = *** TEST FAILED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF '$(FAIL_MSG)' $(LOG); then exit 1; fi; exit $$status

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- all.f
fpga_core_pkg.sv
uart_rx.sv
uart_tx.sv
gmii_frame_fifo.sv
fpga_core.sv
tb_fpga_core.sv

//--- fpga_core.sv
// Top-level core logic for the network test board; wires the UART echo and GMII loopback paths
`timescale 1ns/100ps

module fpga_core (
    input  logic       clk,
    input  logic       rst_n,

    // UART, 115200 bps 8N1
    input  logic       uart_rxd,
    output logic       uart_txd,
    output logic       uart_rts,

    // GMII, byte transfers on enabled cycles only
    input  logic       gmii_clk_en,
    input  logic [7:0] gmii_rxd,
    input  logic       gmii_rx_dv,
    input  logic       gmii_rx_er,
    output logic [7:0] gmii_txd,
    output logic       gmii_tx_en,
    output logic       gmii_tx_er,

    output logic [7:0] led
);

    import fpga_core_pkg::*;

    logic [UART_DATA_W-1:0] rx_data;
    logic                   rx_valid;
    logic                   rx_ready;
    logic                   uart_frame_error;
    logic                   uart_overrun;

    logic [3:0]             good_frames;
    logic [3:0]             bad_frames;

    // No flow control from the host side
    assign uart_rts = 1'b0;

    uart_rx uart_rx_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .rxd         (uart_rxd),
        .data        (rx_data),
        .valid       (rx_valid),
        .ready       (rx_ready),
        .frame_error (uart_frame_error),
        .overrun     (uart_overrun)
    );

    // Receiver output loops straight back into the transmitter
    uart_tx uart_tx_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .data  (rx_data),
        .valid (rx_valid),
        .ready (rx_ready),
        .txd   (uart_txd)
    );

    gmii_frame_fifo gmii_fifo_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .clk_en      (gmii_clk_en),
        .rxd         (gmii_rxd),
        .rx_dv       (gmii_rx_dv),
        .rx_er       (gmii_rx_er),
        .txd         (gmii_txd),
        .tx_en       (gmii_tx_en),
        .tx_er       (gmii_tx_er),
        .good_frames (good_frames),
        .bad_frames  (bad_frames)
    );

    assign led = {uart_overrun, uart_frame_error, bad_frames[1:0], good_frames};

endmodule

//--- fpga_core_pkg.sv
// Shared timing and sizing constants for the network test board core; imported by each block
package fpga_core_pkg;

    // UART timing
    // 50 MHz system clock at 115200 bps gives 434 cycles per bit
    localparam logic [15:0] UART_BIT_CYCLES = 16'd434;

    // UART character width, 8N1 framing
    localparam int UART_DATA_W = 8;

    // GMII frame buffer
    // 2048 entries, each one byte plus an end-of-frame marker
    localparam int GMII_FIFO_ADDR_W = 11;

    // Longest frame accepted into the buffer, in bytes
    // Anything longer is dropped whole and counted as bad
    localparam int GMII_MAX_FRAME = 1536;

    // Minimum idle gap between transmitted frames
    // Counted in enabled cycles only, so it tracks the PHY byte rate
    localparam logic [7:0] GMII_IFG = 8'd12;

endpackage

//--- gmii_frame_fifo.sv
// Store-and-forward GMII frame buffer; drops bad or oversize frames and replays good ones with a gap
`timescale 1ns/100ps

module gmii_frame_fifo (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clk_en,
    input  logic [7:0] rxd,
    input  logic       rx_dv,
    input  logic       rx_er,
    output logic [7:0] txd,
    output logic       tx_en,
    output logic       tx_er,
    output logic [3:0] good_frames,
    output logic [3:0] bad_frames
);

    import fpga_core_pkg::*;

    // Entry is {last, byte}
    logic [8:0] mem [2**GMII_FIFO_ADDR_W];

    // One extra bit on each pointer to tell full from empty
    logic [GMII_FIFO_ADDR_W:0] wr_ptr;
    logic [GMII_FIFO_ADDR_W:0] commit_ptr;
    logic [GMII_FIFO_ADDR_W:0] rd_ptr;
    logic [GMII_FIFO_ADDR_W:0] frame_len;

    logic       in_frame;
    logic       drop;
    // Each byte is held back one cycle so the last one can be flagged
    logic [7:0] hold;

    logic       full;
    logic       mid_write;
    logic       end_good;
    logic       mem_we;

    logic [8:0] rd_word;
    logic       tx_last;
    logic [7:0] gap_cnt;
    logic       tx_start;
    logic       rd_en;

    always_comb begin
        full      = (wr_ptr - rd_ptr) == {1'b1, {GMII_FIFO_ADDR_W{1'b0}}};
        mid_write = clk_en && in_frame && rx_dv && !drop && !rx_er && !full &&
                    frame_len != (GMII_FIFO_ADDR_W + 1)'(GMII_MAX_FRAME);
        end_good  = clk_en && in_frame && !rx_dv && !drop && !full;
        mem_we    = mid_write || end_good;
    end

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[wr_ptr[GMII_FIFO_ADDR_W-1:0]] <= {end_good, hold};
        end
        if (clk_en && rx_dv && (!in_frame || mid_write)) begin
            hold <= rxd;
        end
    end

    // Receive side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            commit_ptr  <= '0;
            frame_len   <= '0;
            in_frame    <= 1'b0;
            drop        <= 1'b0;
            good_frames <= '0;
            bad_frames  <= '0;
        end else if (clk_en) begin
            if (rx_dv) begin
                if (!in_frame) begin
                    in_frame  <= 1'b1;
                    drop      <= rx_er;
                    frame_len <= 1;
                end else if (mid_write) begin
                    wr_ptr    <= wr_ptr + 1'b1;
                    frame_len <= frame_len + 1'b1;
                end else begin
                    // Error, oversize or no room drops the rest of the frame
                    drop <= 1'b1;
                end
            end else if (in_frame) begin
                in_frame <= 1'b0;
                if (end_good) begin
                    wr_ptr      <= wr_ptr + 1'b1;
                    commit_ptr  <= wr_ptr + 1'b1;
                    good_frames <= good_frames + 4'd1;
                end else begin
                    wr_ptr     <= commit_ptr;
                    bad_frames <= bad_frames + 4'd1;
                end
            end
        end
    end

    // Transmit side
    assign tx_start = !tx_en && gap_cnt == GMII_IFG && commit_ptr != rd_ptr;
    assign rd_en    = clk_en && (tx_start || (tx_en && !tx_last));

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word <= mem[rd_ptr[GMII_FIFO_ADDR_W-1:0]];
        end
    end

    assign txd     = rd_word[7:0];
    assign tx_last = rd_word[8];
    assign tx_er   = 1'b0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr  <= '0;
            tx_en   <= 1'b0;
            gap_cnt <= '0;
        end else if (clk_en) begin
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (tx_start) begin
                tx_en   <= 1'b1;
                gap_cnt <= '0;
            end else if (tx_en && tx_last) begin
                tx_en <= 1'b0;
            end else if (!tx_en && gap_cnt != GMII_IFG) begin
                gap_cnt <= gap_cnt + 8'd1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(tx_en) |-> $past(gap_cnt) == GMII_IFG && $past(clk_en));

    // Data only matters while tx_en is high
    assert property (@(posedge clk) disable iff (!rst_n)
        !clk_en |=> $stable(tx_en) && (!tx_en || $stable(txd)));

endmodule

//--- tb_fpga_core.sv
// Self-checking testbench for the network test board core; drives UART and GMII, compile with all.f
`timescale 1ns/100ps

module tb_fpga_core;

    import fpga_core_pkg::*;

    logic       clk;
    logic       rst_n;
    logic       uart_rxd;
    logic       uart_txd;
    logic       uart_rts;
    logic       gmii_clk_en;
    logic [7:0] gmii_rxd;
    logic       gmii_rx_dv;
    logic       gmii_rx_er;
    logic [7:0] gmii_txd;
    logic       gmii_tx_en;
    logic       gmii_tx_er;
    logic [7:0] led;

    int          errors;
    int          tests_passed;
    int          tests_failed;
    logic [15:0] lfsr;
    logic        random_en;
    logic [7:0]  en_bits;

    logic [7:0] frame [0:2047];
    logic [7:0] uart_sent [0:2];
    logic [7:0] uart_got [$];
    logic [7:0] exp_bytes [$];
    int         exp_lens [$];
    logic [7:0] got_bytes [$];
    int         got_lens [$];

    fpga_core uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .uart_rxd    (uart_rxd),
        .uart_txd    (uart_txd),
        .uart_rts    (uart_rts),
        .gmii_clk_en (gmii_clk_en),
        .gmii_rxd    (gmii_rxd),
        .gmii_rx_dv  (gmii_rx_dv),
        .gmii_rx_er  (gmii_rx_er),
        .gmii_txd    (gmii_txd),
        .gmii_tx_en  (gmii_tx_en),
        .gmii_tx_er  (gmii_tx_er),
        .led         (led)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Fibonacci form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input int exp_v, input int act_v);
        assert (exp_v == act_v) else begin
            $display("mismatch %s: expected %0h, actual %0h", name, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int e0);
        if (errors == e0) begin
            $display("PASS  %s", name);
            tests_passed++;
        end else begin
            $display("FAIL  %s (%0d errors)", name, errors - e0);
            tests_failed++;
        end
    endtask

    // Random enable pattern during the gating test, otherwise always enabled
    always @(posedge clk) begin
        if (random_en) begin
            take_bits(1, en_bits);
            gmii_clk_en <= en_bits[0];
        end else begin
            gmii_clk_en <= 1'b1;
        end
    end

    // Serial decoder on uart_txd that samples at mid-bit
    logic        mon_busy;
    logic [15:0] mon_cnt;
    logic [3:0]  mon_bit;
    logic [7:0]  mon_byte;

    always @(posedge clk) begin
        if (!rst_n) begin
            mon_busy <= 1'b0;
        end else if (!mon_busy) begin
            if (!uart_txd) begin
                mon_busy <= 1'b1;
                mon_cnt  <= UART_BIT_CYCLES >> 1;
                mon_bit  <= 4'd0;
            end
        end else if (mon_cnt != 16'd0) begin
            mon_cnt <= mon_cnt - 16'd1;
        end else if (mon_bit == 4'd9) begin
            if (!uart_txd) begin
                $display("echoed UART byte has a low stop bit");
                errors++;
            end
            uart_got.push_back(mon_byte);
            mon_busy <= 1'b0;
        end else begin
            if (mon_bit != 4'd0) begin
                mon_byte <= {uart_txd, mon_byte[7:1]};
            end
            mon_bit <= mon_bit + 4'd1;
            mon_cnt <= UART_BIT_CYCLES - 16'd1;
        end
    end

    // Frame collector that counts enabled cycles only
    int   cur_len;
    int   idle_cycles;
    logic seen_frame;

    always @(posedge clk) begin
        if (!rst_n) begin
            cur_len = 0;
            idle_cycles = 0;
            seen_frame = 1'b0;
        end else if (gmii_clk_en) begin
            if (gmii_tx_en) begin
                if (cur_len == 0 && seen_frame) begin
                    assert (idle_cycles >= int'(GMII_IFG)) else begin
                        $display("gap of %0d enabled idle cycles between frames is too short",
                                 idle_cycles);
                        errors++;
                    end
                end
                got_bytes.push_back(gmii_txd);
                cur_len++;
            end else if (cur_len != 0) begin
                got_lens.push_back(cur_len);
                cur_len = 0;
                idle_cycles = 1;
                seen_frame = 1'b1;
            end else begin
                idle_cycles++;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !gmii_tx_er)
        else begin
            $display("gmii_tx_er went high");
            errors++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) !led[7])
        else begin
            $display("UART overrun flag set although the echo never fell behind");
            errors++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) led[6] |=> led[6])
        else begin
            $display("UART frame error flag cleared by itself");
            errors++;
        end

    task automatic send_uart(input logic [7:0] b, input logic stop);
        logic [9:0] bits;
        int i;
        bits = {stop, b, 1'b0};
        for (i = 0; i < 10; i++) begin
            uart_rxd <= bits[i];
            repeat (UART_BIT_CYCLES) @(posedge clk);
        end
        uart_rxd <= 1'b1;
        repeat (2 * int'(UART_BIT_CYCLES)) @(posedge clk);
    endtask

    task automatic wait_uart(input int n);
        int guard;
        for (guard = 0; guard < 40 * int'(UART_BIT_CYCLES) && uart_got.size() < n; guard++) begin
            @(posedge clk);
        end
        if (uart_got.size() < n) begin
            $display("timeout: only %0d of %0d bytes echoed on UART", uart_got.size(), n);
            errors++;
        end
    endtask

    task automatic make_frame(input int len, input logic keep);
        int i;
        logic [7:0] b;
        for (i = 0; i < len; i++) begin
            take_bits(8, b);
            frame[i] = b;
            if (keep) begin
                exp_bytes.push_back(b);
            end
        end
        if (keep) begin
            exp_lens.push_back(len);
        end
    endtask

    // Holds each byte until an enabled cycle takes it
    // The final idle cycle commits the frame
    task automatic send_frame(input int len, input int er_idx);
        int i;
        int guard;
        i = 0;
        guard = 0;
        while (i <= len && guard < 64 * (len + 1)) begin
            gmii_rx_dv <= (i < len);
            gmii_rxd   <= (i < len) ? frame[i] : 8'h00;
            gmii_rx_er <= (i == er_idx);
            @(posedge clk);
            if (gmii_clk_en) begin
                i++;
            end
            guard++;
        end
        if (i <= len) begin
            $display("timeout: GMII clock enable stayed low while sending a frame");
            errors++;
        end
        gmii_rx_dv <= 1'b0;
        gmii_rx_er <= 1'b0;
    endtask

    task automatic wait_frames(input int n);
        int guard;
        for (guard = 0; guard < 20000 && got_lens.size() < n; guard++) begin
            @(posedge clk);
        end
        if (got_lens.size() < n) begin
            $display("timeout: only %0d of %0d frames came back on GMII", got_lens.size(), n);
            errors++;
        end
    endtask

    task automatic clear_frames();
        exp_bytes.delete();
        exp_lens.delete();
        got_bytes.delete();
        got_lens.delete();
    endtask

    task automatic compare_frames(input string name);
        int i;
        int e0;
        check_value({name, " frame count"}, exp_lens.size(), got_lens.size());
        for (i = 0; i < exp_lens.size() && i < got_lens.size(); i++) begin
            check_value({name, " frame length"}, exp_lens[i], got_lens[i]);
        end
        e0 = errors;
        for (i = 0; i < exp_bytes.size() && i < got_bytes.size() && errors == e0; i++) begin
            check_value($sformatf("%s byte %0d", name, i), int'(exp_bytes[i]),
                        int'(got_bytes[i]));
        end
    endtask

    initial begin
        int         i;
        int         e0;
        logic [7:0] b;
        logic [1:0] bad_before;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        lfsr         = 16'd6;
        random_en    = 1'b0;
        rst_n        = 1'b0;
        uart_rxd     = 1'b1;
        gmii_clk_en  = 1'b1;
        gmii_rxd     = 8'h00;
        gmii_rx_dv   = 1'b0;
        gmii_rx_er   = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        e0 = errors;
        check_value("reset uart_txd", 1, int'(uart_txd));
        check_value("reset uart_rts", 0, int'(uart_rts));
        check_value("reset gmii_tx_en", 0, int'(gmii_tx_en));
        check_value("reset gmii_tx_er", 0, int'(gmii_tx_er));
        check_value("reset led", 0, int'(led));
        report_test("reset state", e0);

        e0 = errors;
        uart_got.delete();
        for (i = 0; i < 3; i++) begin
            take_bits(8, b);
            uart_sent[i] = b;
            send_uart(b, 1'b1);
        end
        wait_uart(3);
        for (i = 0; i < 3 && i < uart_got.size(); i++) begin
            check_value($sformatf("uart echo byte %0d", i), int'(uart_sent[i]),
                        int'(uart_got[i]));
        end
        check_value("uart echo led[7:6]", 0, int'(led[7:6]));
        report_test("uart echo", e0);

        // Stop bit held low, so the receiver must drop the byte
        e0 = errors;
        uart_got.delete();
        take_bits(8, b);
        send_uart(b, 1'b0);
        repeat (12 * int'(UART_BIT_CYCLES)) @(posedge clk);
        check_value("uart frame error echo count", 0, uart_got.size());
        check_value("uart frame error led[6]", 1, int'(led[6]));
        // A following good byte still echoes while the flag stays set
        take_bits(8, b);
        send_uart(b, 1'b1);
        wait_uart(1);
        if (uart_got.size() > 0) begin
            check_value("uart frame error recovery byte", int'(b), int'(uart_got[0]));
        end
        report_test("uart frame error", e0);

        // Longer frame first, so the short one queues behind it and the gap is exercised
        e0 = errors;
        clear_frames();
        make_frame(100, 1'b1);
        send_frame(100, -1);
        make_frame(64, 1'b1);
        send_frame(64, -1);
        wait_frames(2);
        compare_frames("gmii good frames");
        check_value("gmii good frames led[3:0]", 2, int'(led[3:0]));
        report_test("gmii good frames", e0);

        e0 = errors;
        clear_frames();
        bad_before = led[5:4];
        make_frame(80, 1'b0);
        send_frame(80, 10);
        make_frame(GMII_MAX_FRAME + 4, 1'b0);
        send_frame(GMII_MAX_FRAME + 4, -1);
        make_frame(60, 1'b1);
        send_frame(60, -1);
        wait_frames(1);
        // Extra time so a wrongly forwarded frame would show up
        repeat (200) @(posedge clk);
        compare_frames("gmii bad frames");
        check_value("gmii bad frames led[5:4]", int'(bad_before + 2'd2), int'(led[5:4]));
        check_value("gmii bad frames led[3:0]", 3, int'(led[3:0]));
        report_test("gmii bad frames", e0);

        e0 = errors;
        clear_frames();
        make_frame(70, 1'b1);
        random_en <= 1'b1;
        send_frame(70, -1);
        wait_frames(1);
        compare_frames("gmii clock enable");
        random_en <= 1'b0;
        report_test("gmii clock enable", e0);

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- uart_rx.sv
// UART 8N1 receiver; presents each received byte on a valid/ready pair with sticky error flags
`timescale 1ns/100ps

module uart_rx (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 rxd,
    output logic [fpga_core_pkg::UART_DATA_W-1:0] data,
    output logic                                 valid,
    input  logic                                 ready,
    output logic                                 frame_error,
    output logic                                 overrun
);

    import fpga_core_pkg::*;

    // Two-flop synchronizer plus one more stage for edge detection
    logic rxd_meta;
    logic rxd_sync;
    logic rxd_prev;

    logic                   busy;
    logic [15:0]            cnt;
    logic [3:0]             bit_idx;
    logic [UART_DATA_W-1:0] shreg;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    // bit_idx 0 is the start bit, 1..UART_DATA_W the data, then the stop bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            cnt         <= '0;
            bit_idx     <= '0;
            shreg       <= '0;
            data        <= '0;
            valid       <= 1'b0;
            frame_error <= 1'b0;
            overrun     <= 1'b0;
        end else begin
            if (valid && ready) begin
                valid <= 1'b0;
            end

            if (!busy) begin
                // Falling edge only, so a held-low line after a bad stop bit is ignored
                if (rxd_prev && !rxd_sync) begin
                    busy    <= 1'b1;
                    bit_idx <= '0;
                    cnt     <= (UART_BIT_CYCLES >> 1) - 16'd1;
                end
            end else if (cnt != '0) begin
                cnt <= cnt - 16'd1;
            end else if (bit_idx == '0) begin
                // Mid start bit; a high line here was only a glitch
                if (rxd_sync) begin
                    busy <= 1'b0;
                end else begin
                    bit_idx <= 4'd1;
                    cnt     <= UART_BIT_CYCLES - 16'd1;
                end
            end else if (bit_idx <= 4'(UART_DATA_W)) begin
                // LSB arrives first
                shreg   <= {rxd_sync, shreg[UART_DATA_W-1:1]};
                bit_idx <= bit_idx + 4'd1;
                cnt     <= UART_BIT_CYCLES - 16'd1;
            end else begin
                busy <= 1'b0;
                if (!rxd_sync) begin
                    frame_error <= 1'b1;
                end else if (valid && !ready) begin
                    // Previous byte still waiting, this one is lost
                    overrun <= 1'b1;
                end else begin
                    data  <= shreg;
                    valid <= 1'b1;
                end
            end
        end
    end

    // A held byte must survive until the transmitter takes it
    assert property (@(posedge clk) disable iff (!rst_n)
        valid && !ready |=> valid && $stable(data));

endmodule

//--- uart_tx.sv
// UART 8N1 transmitter; takes bytes on a valid/ready pair and shifts them out LSB first
`timescale 1ns/100ps

module uart_tx (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [fpga_core_pkg::UART_DATA_W-1:0] data,
    input  logic                                 valid,
    output logic                                 ready,
    output logic                                 txd
);

    import fpga_core_pkg::*;

    logic                 busy;
    logic [15:0]          cnt;
    logic [3:0]           bits_left;
    // Data bits followed by the stop bit
    logic [UART_DATA_W:0] shreg;

    assign ready = !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            txd       <= 1'b1;
            cnt       <= '0;
            bits_left <= '0;
            shreg     <= '1;
        end else if (!busy) begin
            if (valid) begin
                // Start bit goes out right away
                busy      <= 1'b1;
                txd       <= 1'b0;
                shreg     <= {1'b1, data};
                cnt       <= UART_BIT_CYCLES - 16'd1;
                bits_left <= 4'(UART_DATA_W + 1);
            end
        end else if (cnt != '0) begin
            cnt <= cnt - 16'd1;
        end else if (bits_left == '0) begin
            // End of stop bit
            busy <= 1'b0;
        end else begin
            txd       <= shreg[0];
            shreg     <= {1'b1, shreg[UART_DATA_W:1]};
            bits_left <= bits_left - 4'd1;
            cnt       <= UART_BIT_CYCLES - 16'd1;
        end
    end

    // Line idles high whenever a new byte may be taken
    assert property (@(posedge clk) disable iff (!rst_n)
        ready |-> txd);

endmodule
